// File: source/chipRam_cfg.svh
`ifndef CHIPRAM_CFG_SVH
`define CHIPRAM_CFG_SVH

//////////////////////////////
// Refresh
//////////////////////////////

// 8192 refreshes per 64 ms gives one every 7.8 us
// About 28 cycles of a 3.55 MHz C1
`define CR_REFRESH_INTERVAL 8'd27

//////////////////////////////
// Power-up sequence
//////////////////////////////

// Step 0 issues the all-bank precharge
`define CR_INIT_MRS_STEP 4'd2
`define CR_INIT_REF1_STEP 4'd5
`define CR_INIT_REF2_STEP 4'd9
// Controller goes live on the step after this one
`define CR_INIT_DONE_STEP 4'd13

// Mode register: CAS latency 2, sequential burst of 4
`define CR_MODE_WORD 11'b000_0010_0010

`endif

// File: source/chipRamPkg.sv
package chipRamPkg;

    //////////////////////////////
    // SDRAM command encoding
    //////////////////////////////

    // Pin order is csN rasN casN weN, MSB first
    localparam logic [3:0] cmdNop         = 4'b1111;
    localparam logic [3:0] cmdPrecharge   = 4'b0010;
    localparam logic [3:0] cmdActivate    = 4'b0011;
    localparam logic [3:0] cmdRead        = 4'b0101;
    localparam logic [3:0] cmdWrite       = 4'b0100;
    localparam logic [3:0] cmdAutoRefresh = 4'b0001;
    localparam logic [3:0] cmdModeReg     = 4'b0000;

    // The sequencer writes the code and the pin register reads the strobes
    typedef union packed {
        logic [3:0] code;
        struct packed {
            logic csN;
            logic rasN;
            logic casN;
            logic weN;
        } pins;
    } sdramCmdT;

    //////////////////////////////
    // Bus bundles
    //////////////////////////////

    // CPU side, addr is the word address A20..A1
    typedef struct packed {
        logic        tsN;
        logic        ramSpaceN;
        logic        rnw;
        logic [20:1] addr;
    } cpuReqT;

    // Video/DMA chip DRAM strobes and multiplexed address
    typedef struct packed {
        logic       ras0N;
        logic       ras1N;
        logic       caslN;
        logic       casuN;
        logic       aweN;
        logic       dbrN;
        logic [9:0] dra;
    } agnusBusT;

    // Captured DMA slot
    typedef struct packed {
        logic [9:0] row;
        logic [9:0] col;
        logic       rowBank;
        logic       write;
    } dmaSlotT;

    // SDRAM pins as driven to the device
    typedef struct packed {
        sdramCmdT    cmd;
        logic [10:0] addr;
    } sdramBusT;

endpackage

// File: source/refreshTimer.sv
`include "chipRam_cfg.svh"

module refreshTimer #(
    parameter logic [7:0] refreshInterval = `CR_REFRESH_INTERVAL
) (
    input  logic C1,
    input  logic REFRESH_RST,
    input  logic refreshIssued,
    output logic refreshDue
);

    // Cycles since the last auto-refresh
    logic [7:0] sinceRefresh;

    //////////////////////////////
    // Interval counter
    //////////////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            sinceRefresh <= 8'd0;
        end else if (refreshIssued) begin
            // Restart the interval on every refresh, init ones included
            sinceRefresh <= 8'd0;
        end else if (sinceRefresh != 8'hFF) begin
            // Stop at full scale so a long stall cannot wrap
            sinceRefresh <= sinceRefresh + 8'd1;
        end
    end

    // Due flag stays up until the sequencer gets round to it
    assign refreshDue = (sinceRefresh >= refreshInterval);

endmodule

// File: source/dmaSlotCapture.sv
module dmaSlotCapture (
    input  logic                 C1,
    input  logic                 REFRESH_RST,
    input  chipRamPkg::agnusBusT agnus,
    input  logic                 dmaTaken,
    output logic                 dmaPending,
    output chipRamPkg::dmaSlotT  dmaSlot,
    output logic                 dbrIdle
);

    import chipRamPkg::*;

    // Two sync stages plus one history bit for the edge
    logic [2:0] rasSync;
    logic [2:0] casSync;
    logic [1:0] dbrSync;
    logic       rasFall;
    logic       casFall;

    //////////////////////////////
    // Strobe synchronizers
    //////////////////////////////

    // Strobes idle high, so they come out of reset high
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            rasSync <= 3'b111;
            casSync <= 3'b111;
            dbrSync <= 2'b11;
        end else begin
            // Either RAS low counts as a row strobe
            rasSync <= {rasSync[1:0], agnus.ras0N & agnus.ras1N};
            // Either byte lane CAS counts as a column strobe
            casSync <= {casSync[1:0], agnus.caslN & agnus.casuN};
            dbrSync <= {dbrSync[0], agnus.dbrN};
        end
    end

    assign rasFall = rasSync[2] & ~rasSync[1];
    assign casFall = casSync[2] & ~casSync[1];

    // CPU may go only when bus request has read high in both stages
    assign dbrIdle = &dbrSync;

    //////////////////////////////
    // Address capture
    //////////////////////////////

    // dra is stable while the strobe is held low
    always_ff @(posedge C1) begin
        if (rasFall) begin
            dmaSlot.row     <= agnus.dra;
            // ras0N picks the 512K half in the 1 MB map
            dmaSlot.rowBank <= agnus.ras0N;
        end
        if (casFall) begin
            dmaSlot.col   <= agnus.dra;
            dmaSlot.write <= ~agnus.aweN;
        end
    end

    // Request pending
    // a new column strobe wins over the take pulse
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            dmaPending <= 1'b0;
        end else begin
            dmaPending <= casFall | (dmaPending & ~dmaTaken);
        end
    end

endmodule

// File: source/sdramAddrMux.sv
`include "chipRam_cfg.svh"

module sdramAddrMux (
    input  logic                 C1,
    input  logic                 REFRESH_RST,
    input  chipRamPkg::sdramCmdT cmd,
    input  logic                 cpuSel,
    input  logic [20:1]          cpuAddr,
    input  chipRamPkg::dmaSlotT  dmaSlot,
    output chipRamPkg::sdramBusT sdram
);

    import chipRamPkg::*;

    // Registered pin state, joined onto the bus below
    sdramCmdT    pinCmd;
    logic [10:0] pinAddr;

    //////////////////////////////
    // Command pins
    //////////////////////////////

    // Pins lag the sequencer command by one cycle
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            pinCmd.code <= cmdNop;
        end else begin
            pinCmd.pins <= cmd.pins;
        end
    end

    //////////////////////////////
    // Address pins
    //////////////////////////////

    // Video chip multiplexing for the 1 MB map
    //   row  A19 A17..A9
    //   col  A18 A8..A2
    // Column bit 0 of the DMA slot drives the buffer enable instead
    always_ff @(posedge C1) begin
        case (cmd.code)
            // A10 high precharges every bank
            cmdPrecharge: pinAddr <= 11'b100_0000_0000;
            cmdModeReg:   pinAddr <= `CR_MODE_WORD;
            cmdActivate: begin
                if (cpuSel) begin
                    pinAddr <= {1'b0, cpuAddr[19], cpuAddr[17:9]};
                end else begin
                    pinAddr <= {1'b0, dmaSlot.rowBank, dmaSlot.row[8:0]};
                end
            end
            cmdRead, cmdWrite: begin
                if (cpuSel) begin
                    pinAddr <= {3'b000, cpuAddr[18], cpuAddr[8:2]};
                end else begin
                    pinAddr <= {3'b000, dmaSlot.col[8:1]};
                end
            end
            // NOP and refresh leave the bus as it was
            default: pinAddr <= pinAddr;
        endcase
    end

    assign sdram = {pinCmd, pinAddr};

endmodule

// File: source/sdramSequencer.sv
`include "chipRam_cfg.svh"

module sdramSequencer (
    input  logic                 C1,
    input  logic                 REFRESH_RST,
    input  chipRamPkg::cpuReqT   cpu,
    input  logic                 dmaPending,
    input  logic                 dmaWrite,
    input  logic                 dmaCol0,
    input  logic                 dbrIdle,
    input  logic                 refreshDue,
    output chipRamPkg::sdramCmdT cmd,
    output logic                 cpuSel,
    output logic                 refreshIssued,
    output logic                 dmaTaken,
    output logic                 cpuTack,
    output logic                 cpuCycle,
    output logic                 dmaCycle,
    output logic                 dbEnN,
    output logic                 dbDir
);

    import chipRamPkg::*;

    // Step counter, shared by init, refresh and access
    logic [3:0] step;
    logic       configured;
    logic       refreshCycle;
    logic       writeCycle;
    logic       cpuPending;
    logic       cpuReq;
    logic       idle;
    logic       dmaStart;
    logic       cpuStart;

    //////////////////////////////
    // Arbitration
    //////////////////////////////

    // CPU request is transfer start inside chip RAM space
    assign cpuReq = ~cpu.tsN & ~cpu.ramSpaceN;

    // Idle only after init and with no cycle in flight
    assign idle = configured & ~refreshCycle & ~cpuCycle & ~dmaCycle;

    // Refresh first, then DMA, then CPU
    assign dmaStart = idle & ~refreshDue & dmaPending;
    // CPU waits while the video chip holds the bus request
    assign cpuStart = idle & ~refreshDue & ~dmaPending & cpuPending & dbrIdle;

    assign dmaTaken      = dmaStart;
    assign refreshIssued = (cmd.code == cmdAutoRefresh);
    // Address mux follows the owner of the current access
    assign cpuSel        = cpuCycle;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            cmd.code     <= cmdNop;
            step         <= 4'd0;
            configured   <= 1'b0;
            refreshCycle <= 1'b0;
            writeCycle   <= 1'b0;
            cpuPending   <= 1'b0;
            cpuTack      <= 1'b0;
            cpuCycle     <= 1'b0;
            dmaCycle     <= 1'b0;
            dbEnN        <= 1'b1;
            dbDir        <= 1'b1;
        end else begin
            // Steps run on by themselves once started
            if (step != 4'd0) begin
                step <= step + 4'd1;
            end

            // Hold the CPU request until it is admitted
            // fresh strobes during its own cycle are ignored
            cpuPending <= (cpuPending & ~cpuStart) | (cpuReq & ~cpuCycle & ~cpuStart);

            if (!configured) begin
                // Power-up sequence
                case (step)
                    4'd0: begin
                        cmd.code <= cmdPrecharge;
                        step     <= 4'd1;
                    end
                    `CR_INIT_MRS_STEP: begin
                        cmd.code <= cmdModeReg;
                    end
                    `CR_INIT_REF1_STEP, `CR_INIT_REF2_STEP: begin
                        cmd.code <= cmdAutoRefresh;
                    end
                    `CR_INIT_DONE_STEP: begin
                        cmd.code   <= cmdNop;
                        configured <= 1'b1;
                        step       <= 4'd0;
                    end
                    default: begin
                        cmd.code <= cmdNop;
                    end
                endcase
            end else if (refreshCycle) begin
                // tRFC covered by three NOP steps
                cmd.code <= cmdNop;
                if (step == 4'd3) begin
                    refreshCycle <= 1'b0;
                    step         <= 4'd0;
                end
            end else if (cpuCycle || dmaCycle) begin
                // Fixed access cycle
                case (step)
                    4'd2: begin
                        // CAS latency 2 from here
                        cmd.code <= writeCycle ? cmdWrite : cmdRead;
                    end
                    4'd3: begin
                        cmd.code <= cmdPrecharge;
                    end
                    4'd4: begin
                        cmd.code <= cmdNop;
                        // Read data is valid by the next step
                        cpuTack  <= cpuCycle;
                    end
                    4'd5: begin
                        cmd.code <= cmdNop;
                        cpuTack  <= 1'b0;
                    end
                    4'd7: begin
                        cmd.code <= cmdNop;
                        cpuCycle <= 1'b0;
                        dmaCycle <= 1'b0;
                        dbEnN    <= 1'b1;
                        dbDir    <= 1'b1;
                        step     <= 4'd0;
                    end
                    default: begin
                        cmd.code <= cmdNop;
                    end
                endcase
            end else if (refreshDue) begin
                // Refresh wins any idle slot
                cmd.code     <= cmdAutoRefresh;
                refreshCycle <= 1'b1;
                step         <= 4'd1;
            end else if (dmaStart) begin
                cmd.code   <= cmdActivate;
                dmaCycle   <= 1'b1;
                writeCycle <= dmaWrite;
                // Column bit 0 selects the buffer for DMA
                dbEnN      <= ~dmaCol0;
                dbDir      <= ~dmaWrite;
                step       <= 4'd1;
            end else if (cpuStart) begin
                cmd.code   <= cmdActivate;
                cpuCycle   <= 1'b1;
                writeCycle <= ~cpu.rnw;
                // Buffer toward the video chip stays off for CPU cycles
                dbEnN      <= 1'b1;
                dbDir      <= cpu.rnw;
                step       <= 4'd1;
            end else begin
                cmd.code <= cmdNop;
            end
        end
    end

endmodule

// File: source/chipRamTop.sv
`include "chipRam_cfg.svh"

module chipRamTop #(
    parameter logic [7:0] refreshInterval = `CR_REFRESH_INTERVAL
) (
    input  logic                 C1,
    input  logic                 REFRESH_RST,
    input  chipRamPkg::cpuReqT   cpu,
    input  chipRamPkg::agnusBusT agnus,
    output chipRamPkg::sdramBusT sdram,
    output logic                 cpuTack,
    output logic                 cpuCycle,
    output logic                 dmaCycle,
    output logic                 dbEnN,
    output logic                 dbDir
);

    import chipRamPkg::*;

    // Internal links between the blocks
    logic     refreshDue;
    logic     refreshIssued;
    logic     dmaPending;
    logic     dmaTaken;
    logic     dbrIdle;
    logic     cpuSel;
    dmaSlotT  dmaSlot;
    sdramCmdT cmd;

    //////////////////////////////
    // Refresh and DMA capture
    //////////////////////////////

    refreshTimer #(
        .refreshInterval(refreshInterval)
    ) refreshTimer0 (
        .C1           (C1),
        .REFRESH_RST  (REFRESH_RST),
        .refreshIssued(refreshIssued),
        .refreshDue   (refreshDue)
    );

    dmaSlotCapture dmaSlotCapture0 (
        .C1         (C1),
        .REFRESH_RST(REFRESH_RST),
        .agnus      (agnus),
        .dmaTaken   (dmaTaken),
        .dmaPending (dmaPending),
        .dmaSlot    (dmaSlot),
        .dbrIdle    (dbrIdle)
    );

    //////////////////////////////
    // Sequencer and pin drive
    //////////////////////////////

    sdramSequencer sdramSequencer0 (
        .C1           (C1),
        .REFRESH_RST  (REFRESH_RST),
        .cpu          (cpu),
        .dmaPending   (dmaPending),
        .dmaWrite     (dmaSlot.write),
        .dmaCol0      (dmaSlot.col[0]),
        .dbrIdle      (dbrIdle),
        .refreshDue   (refreshDue),
        .cmd          (cmd),
        .cpuSel       (cpuSel),
        .refreshIssued(refreshIssued),
        .dmaTaken     (dmaTaken),
        .cpuTack      (cpuTack),
        .cpuCycle     (cpuCycle),
        .dmaCycle     (dmaCycle),
        .dbEnN        (dbEnN),
        .dbDir        (dbDir)
    );

    sdramAddrMux sdramAddrMux0 (
        .C1         (C1),
        .REFRESH_RST(REFRESH_RST),
        .cmd        (cmd),
        .cpuSel     (cpuSel),
        .cpuAddr    (cpu.addr),
        .dmaSlot    (dmaSlot),
        .sdram      (sdram)
    );

endmodule

// File: verif/chipRam_asserts.sv
module chipRamAsserts (
    input logic                 C1,
    input logic                 REFRESH_RST,
    input chipRamPkg::sdramCmdT cmd,
    input logic                 refreshIssued,
    input logic                 cpuTack,
    input logic                 cpuCycle,
    input logic                 dmaCycle
);

    import chipRamPkg::*;

    // Cycles since the last ACTIVATE, saturating
    logic [3:0] sinceActivate;

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            sinceActivate <= 4'hF;
        end else if (cmd.code == cmdActivate) begin
            sinceActivate <= 4'd0;
        end else if (sinceActivate != 4'hF) begin
            sinceActivate <= sinceActivate + 4'd1;
        end
    end

    //////////////////////////////
    // Protocol properties
    //////////////////////////////

    // One owner of the SDRAM at a time
    ownerUnique: assert property (@(posedge C1) disable iff (REFRESH_RST)
        !(cpuCycle && dmaCycle))
        else $error("CPU and DMA cycles overlap");

    tackInCycle: assert property (@(posedge C1) disable iff (REFRESH_RST)
        cpuTack |-> cpuCycle)
        else $error("cpuTack outside a CPU cycle");

    refreshOutside: assert property (@(posedge C1) disable iff (REFRESH_RST)
        refreshIssued |-> !(cpuCycle || dmaCycle))
        else $error("Auto-refresh inside an access");

    // A gap of 8 cycles reads as 7 here
    activateSpacing: assert property (@(posedge C1) disable iff (REFRESH_RST)
        (cmd.code == cmdActivate) |-> (sinceActivate >= 4'd7))
        else $error("Two ACTIVATE commands within 8 cycles");

endmodule

bind sdramSequencer chipRamAsserts chipRamAsserts0 (
    .C1           (C1),
    .REFRESH_RST  (REFRESH_RST),
    .cmd          (cmd),
    .refreshIssued(refreshIssued),
    .cpuTack      (cpuTack),
    .cpuCycle     (cpuCycle),
    .dmaCycle     (dmaCycle)
);

// File: verif/chipRamTb.sv
module chipRamTb;

    import chipRamPkg::*;

    // Short refresh interval so the run sees several refreshes
    localparam int intervalCycles = 40;
    localparam int refreshLimit = intervalCycles + 12;
    // CAS latency 2 in A6..A4, sequential burst of 4 in A3..A0
    localparam logic [10:0] modeExpected = {4'b0000, 3'd2, 1'b0, 3'b010};

    logic        C1 = 1'b0;
    logic        REFRESH_RST;
    cpuReqT      cpu;
    agnusBusT    agnus;
    sdramBusT    sdram;
    logic        cpuTack;
    logic        cpuCycle;
    logic        dmaCycle;
    logic        dbEnN;
    logic        dbDir;
    int          checkCount = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;

    always #2 C1 = ~C1;

    chipRamTop #(
        .refreshInterval(8'(intervalCycles))
    ) dut0 (
        .C1         (C1),
        .REFRESH_RST(REFRESH_RST),
        .cpu        (cpu),
        .agnus      (agnus),
        .sdram      (sdram),
        .cpuTack    (cpuTack),
        .cpuCycle   (cpuCycle),
        .dmaCycle   (dmaCycle),
        .dbEnN      (dbEnN),
        .dbDir      (dbDir)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Drive point, 1 unit after the rising edge
    task automatic nextCycle();
        @(posedge C1);
        #1;
    endtask

    task automatic expectEqual(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            valueErrors++;
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic waitForCommand(input logic [3:0] code, input int limit,
                                  input string what, output int waited);
        waited = 0;
        while (sdram.cmd.code != code && waited < limit) begin
            nextCycle();
            waited++;
        end
        if (sdram.cmd.code != code) begin
            otherErrors++;
            $display("Timeout: no %s reached the SDRAM pins within %0d cycles", what, limit);
        end
    endtask

    // Power-up order, offset counted from the PRECHARGE on the pins
    function automatic logic [3:0] initCommand(input int offset);
        case (offset)
            2:       return cmdModeReg;
            5, 9:    return cmdAutoRefresh;
            default: return cmdNop;
        endcase
    endfunction

    // Follow one access from ACTIVATE on the pins to the idle slot
    task automatic accessCycle(input logic isCpu, input logic isWrite,
                               input logic [10:0] rowAddr, input logic [10:0] colAddr,
                               input logic enN);
        int waited;
        int tacks;
        tacks = 0;
        waitForCommand(cmdActivate, 120, "ACTIVATE", waited);
        expectEqual("sdram.addr row", 32'(rowAddr), 32'(sdram.addr));
        expectEqual("cpuCycle", 32'(isCpu), 32'(cpuCycle));
        expectEqual("dmaCycle", 32'(!isCpu), 32'(dmaCycle));
        expectEqual("dbEnN", 32'(enN), 32'(dbEnN));
        expectEqual("dbDir", 32'(!isWrite), 32'(dbDir));
        // Nothing slips in between the row and column commands
        nextCycle();
        expectEqual("sdram.cmd after row", 32'(cmdNop), 32'(sdram.cmd.code));
        // Column command two cycles after the row
        nextCycle();
        expectEqual("sdram.cmd column", 32'(isWrite ? cmdWrite : cmdRead),
                    32'(sdram.cmd.code));
        expectEqual("sdram.addr column", 32'(colAddr), 32'(sdram.addr));
        nextCycle();
        expectEqual("sdram.cmd precharge", 32'(cmdPrecharge), 32'(sdram.cmd.code));
        expectEqual("sdram.addr precharge", 32'h400, 32'(sdram.addr));
        waited = 0;
        while ((cpuCycle || dmaCycle) && waited < 12) begin
            if (cpuTack) begin
                tacks++;
            end
            nextCycle();
            waited++;
        end
        if (cpuCycle || dmaCycle) begin
            otherErrors++;
            $display("Timeout: access cycle did not return to idle");
        end
        // One acknowledge per CPU request and none for DMA
        expectEqual("cpuTack pulses", 32'(isCpu), 32'(tacks));
        expectEqual("dbEnN idle", 32'h1, 32'(dbEnN));
        expectEqual("dbDir idle", 32'h1, 32'(dbDir));
    endtask

    // Row strobe then column strobe, the way the video chip drives them
    task automatic strobeDma(input logic bank1, input logic [9:0] row, input logic [9:0] col,
                             input logic write, input logic withCpu);
        agnus.dra   = row;
        agnus.ras0N = bank1;
        agnus.ras1N = !bank1;
        repeat (4) nextCycle();
        agnus.dra     = col;
        agnus.aweN    = !write;
        agnus.caslN   = 1'b0;
        repeat (2) nextCycle();
        // Optional CPU strobe, pending on the same edge as the synchronized CAS
        cpu.tsN       = !withCpu;
        cpu.ramSpaceN = !withCpu;
        nextCycle();
        cpu.tsN       = 1'b1;
        cpu.ramSpaceN = 1'b1;
        nextCycle();
        agnus.ras0N = 1'b1;
        agnus.ras1N = 1'b1;
        agnus.caslN = 1'b1;
        agnus.aweN  = 1'b1;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic initSequence();
        int waited;
        REFRESH_RST = 1'b1;
        repeat (4) nextCycle();
        expectEqual("cpuTack reset", 32'h0, 32'(cpuTack));
        expectEqual("cpuCycle reset", 32'h0, 32'(cpuCycle));
        expectEqual("dmaCycle reset", 32'h0, 32'(dmaCycle));
        expectEqual("dbEnN reset", 32'h1, 32'(dbEnN));
        expectEqual("dbDir reset", 32'h1, 32'(dbDir));
        expectEqual("sdram.cmd reset", 32'(cmdNop), 32'(sdram.cmd.code));
        REFRESH_RST = 1'b0;
        waitForCommand(cmdPrecharge, 8, "init PRECHARGE", waited);
        // Registered on the first edge, on the pins after the second
        expectEqual("precharge delay", 32'd2, 32'(waited));
        for (int offset = 1; offset <= 12; offset++) begin
            nextCycle();
            expectEqual("sdram.cmd init", 32'(initCommand(offset)), 32'(sdram.cmd.code));
            if (offset == 2) begin
                expectEqual("sdram.addr mode", 32'(modeExpected), 32'(sdram.addr));
            end
        end
    endtask

    task automatic cpuAccesses();
        logic [31:0] rnd;
        logic [20:1] addr;
        for (int n = 0; n < 6; n++) begin
            rnd           = $urandom();
            addr          = rnd[19:0];
            cpu.addr      = addr;
            cpu.rnw       = rnd[31];
            cpu.tsN       = 1'b0;
            cpu.ramSpaceN = 1'b0;
            nextCycle();
            cpu.tsN       = 1'b1;
            cpu.ramSpaceN = 1'b1;
            // Row A19 A17..A9, column A18 A8..A2
            accessCycle(1'b1, !rnd[31], {1'b0, addr[19], addr[17:9]},
                        {3'b000, addr[18], addr[8:2]}, 1'b1);
        end
    endtask

    task automatic dmaAccesses();
        logic [31:0] rnd;
        logic [9:0]  row;
        logic [9:0]  col;
        logic        write;
        for (int n = 0; n < 4; n++) begin
            rnd   = $urandom();
            row   = rnd[9:0];
            // Walk column bit 0 and the write flag through all pairs
            col   = {rnd[19:11], n[0]};
            write = n[1];
            strobeDma(rnd[20], row, col, write, 1'b0);
            accessCycle(1'b0, write, {1'b0, rnd[20], row[8:0]}, {3'b000, col[8:1]}, !col[0]);
        end
    endtask

    task automatic dmaBeforeCpu();
        logic [31:0] rnd;
        logic [20:1] addr;
        logic [9:0]  row;
        logic [9:0]  col;
        rnd        = $urandom();
        addr       = rnd[19:0];
        row        = rnd[29:20];
        col        = {rnd[28:20], 1'b1};
        cpu.addr   = addr;
        cpu.rnw    = 1'b1;
        // Both requests pending together with the bus request still idle
        strobeDma(1'b0, row, col, 1'b0, 1'b1);
        // Bus request goes low while the DMA cycle runs
        agnus.dbrN = 1'b0;
        accessCycle(1'b0, 1'b0, {2'b00, row[8:0]}, {3'b000, col[8:1]}, 1'b0);
        // CPU stays parked while the bus request is held
        for (int n = 0; n < 16; n++) begin
            nextCycle();
            expectEqual("ACTIVATE under dbrN", 32'h0, 32'(sdram.cmd.code == cmdActivate));
            expectEqual("cpuCycle under dbrN", 32'h0, 32'(cpuCycle));
        end
        agnus.dbrN = 1'b1;
        accessCycle(1'b1, 1'b0, {1'b0, addr[19], addr[17:9]},
                    {3'b000, addr[18], addr[8:2]}, 1'b1);
    endtask

    task automatic refreshSpacing();
        int gap;
        int seen;
        gap  = 0;
        seen = 0;
        for (int n = 0; n < 4 * refreshLimit; n++) begin
            nextCycle();
            gap++;
            if (sdram.cmd.code == cmdAutoRefresh) begin
                seen++;
                gap = 0;
            end
            if (gap > refreshLimit) begin
                otherErrors++;
                $display("No AUTOREFRESH for more than %0d cycles", refreshLimit);
                gap = 0;
            end
        end
        if (seen < 3) begin
            otherErrors++;
            $display("Only %0d refreshes seen in an idle window", seen);
        end
    endtask

    //////////////////////////////
    // Run
    //////////////////////////////

    initial begin
        void'($urandom(32'h95));
        REFRESH_RST = 1'b1;
        // Idle CPU bus and idle video chip strobes
        cpu         = {3'b111, 20'd0};
        agnus       = {6'b111111, 10'd0};
        initSequence();
        cpuAccesses();
        dmaAccesses();
        dmaBeforeCpu();
        refreshSpacing();
        repeat (2) nextCycle();
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+source
source/chipRamPkg.sv
source/refreshTimer.sv
source/dmaSlotCapture.sv
source/sdramAddrMux.sv
source/sdramSequencer.sv
source/chipRamTop.sv
verif/chipRam_asserts.sv
verif/chipRamTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the chip RAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --top-module chipRamTb -f sources.f -o chipRamSim \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/chipRamSim > sim.log 2>&1
cat sim.log

grep -qx "TEST PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
